// ==== src/la_pkg.sv ====
`default_nettype none

package la_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // execute operation selector
    localparam int alu_op_width = 3;
    localparam logic [alu_op_width-1:0] alu_add = 3'd0;
    localparam logic [alu_op_width-1:0] alu_sub = 3'd1;
    localparam logic [alu_op_width-1:0] alu_and = 3'd2;
    localparam logic [alu_op_width-1:0] alu_or  = 3'd3;
    localparam logic [alu_op_width-1:0] alu_lui = 3'd4;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    // 1RI20 opcode, inst[31:25]
    localparam logic [6:0] op_lu12i_w = 7'b0001010;

    // branch opcodes, inst[31:26]
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bne = 6'h17;

    // one instruction word, seen as 3R or as 2RI12/branch
    typedef union packed {
        struct packed {
            logic [16:0] op17;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [5:0]  op6;
            logic [3:0]  op_lo;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri;
    } la_inst_t;

endpackage

`default_nettype wire

// ==== src/pipe_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

interface if_id_if;
    import la_pkg::*;
    logic            valid;
    logic            allowin;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    modport master (output valid, pc, inst, input allowin);
    modport slave (input valid, pc, inst, output allowin);
endinterface

interface id_ex_if;
    import la_pkg::*;
    logic                    valid;
    logic                    allowin;
    logic [xlen-1:0]         pc;
    logic [alu_op_width-1:0] alu_op;
    logic [xlen-1:0]         src1;
    logic [xlen-1:0]         src2;
    logic [4:0]              dest;
    logic                    rf_we;
    logic                    mem_re;
    logic                    mem_we;
    logic [xlen-1:0]         store_data;
    modport master (output valid, pc, alu_op, src1, src2, dest, rf_we, mem_re, mem_we,
                    store_data, input allowin);
    modport slave (input valid, pc, alu_op, src1, src2, dest, rf_we, mem_re, mem_we,
                   store_data, output allowin);
endinterface

interface ex_mem_if;
    import la_pkg::*;
    logic            valid;
    logic            allowin;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
    logic [4:0]      dest;
    logic            rf_we;
    logic            mem_re;
    modport master (output valid, pc, result, dest, rf_we, mem_re, input allowin);
    modport slave (input valid, pc, result, dest, rf_we, mem_re, output allowin);
endinterface

interface mem_wb_if;
    import la_pkg::*;
    logic            valid;
    logic            allowin;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
    logic [4:0]      dest;
    logic            rf_we;
    modport master (output valid, pc, result, dest, rf_we, input allowin);
    modport slave (input valid, pc, result, dest, rf_we, output allowin);
endinterface

// result published back to decode for bypassing
interface fwd_if;
    import la_pkg::*;
    logic            valid;
    logic [4:0]      dest;
    logic [xlen-1:0] data;
    logic            is_load;
    modport producer (output valid, dest, data, is_load);
    modport consumer (input valid, dest, data, is_load);
endinterface

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic                    clk,
    input  logic [4:0]              raddr1,
    input  logic [4:0]              raddr2,
    output logic [la_pkg::xlen-1:0] rdata1,
    output logic [la_pkg::xlen-1:0] rdata2,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [la_pkg::xlen-1:0] wdata
);
    import la_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through to decode
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [la_pkg::xlen-1:0] inst_rdata,
    output logic                    inst_en,
    output logic [la_pkg::xlen-1:0] inst_addr,
    input  logic                    br_taken,
    input  logic [la_pkg::xlen-1:0] br_target,
    if_id_if.master                 to_id
);
    import la_pkg::*;

    logic            if_valid;
    logic [xlen-1:0] if_pc;
    logic [xlen-1:0] next_pc;
    logic            if_allowin;

    // IF always completes, so it only waits on ID
    assign if_allowin = !if_valid || to_id.allowin;
    assign next_pc    = br_taken ? br_target : if_pc + 32'd4;

    // on a stall the current pc is re-read so rdata stays put
    assign inst_en   = 1'b1;
    assign inst_addr = if_allowin ? next_pc : if_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            if_valid <= 1'b0;
            // first next_pc lands on reset_pc
            if_pc    <= reset_pc - 32'd4;
        end else if (if_allowin) begin
            if_valid <= 1'b1;
            if_pc    <= next_pc;
        end
    end

    // word behind a taken branch is dropped here
    assign to_id.valid = if_valid && !br_taken;
    assign to_id.pc    = if_pc;
    assign to_id.inst  = inst_rdata;

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    if_id_if.slave                  from_if,
    id_ex_if.master                 to_ex,
    fwd_if.consumer                 ex_fwd,
    fwd_if.consumer                 mem_fwd,
    output logic [4:0]              raddr1,
    output logic [4:0]              raddr2,
    input  logic [la_pkg::xlen-1:0] rdata1,
    input  logic [la_pkg::xlen-1:0] rdata2,
    output logic                    br_taken,
    output logic [la_pkg::xlen-1:0] br_target
);
    import la_pkg::*;

    logic            id_valid;
    logic [xlen-1:0] id_pc;
    la_inst_t        id_inst;
    logic [9:0]      op10;
    logic [6:0]      op7;
    logic [15:0]     offs16;
    logic [19:0]     si20;
    logic [xlen-1:0] imm_se12;
    logic            is_add, is_sub, is_and, is_or, is_addi;
    logic            is_lu12i, is_ld, is_st, is_beq, is_bne;
    logic            is_3r, use_r1, use_r2;
    logic            ex_hit1, ex_hit2, mem_hit1, mem_hit2;
    logic            load_use, ready_go;
    logic [xlen-1:0] val1, val2;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (from_if.allowin) begin
            id_valid <= from_if.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_if.valid && from_if.allowin) begin
            id_pc   <= from_if.pc;
            id_inst <= from_if.inst;
        end
    end

    // fields spread across the 2RI12 view
    assign op10     = {id_inst.ri.op6, id_inst.ri.op_lo};
    assign op7      = {id_inst.ri.op6, id_inst.ri.op_lo[3]};
    assign offs16   = {id_inst.ri.op_lo, id_inst.ri.imm12};
    assign si20     = {id_inst.ri.op_lo[2:0], id_inst.ri.imm12, id_inst.ri.rj};
    assign imm_se12 = {{20{id_inst.ri.imm12[11]}}, id_inst.ri.imm12};

    assign is_add   = id_inst.r3.op17 == op_add_w;
    assign is_sub   = id_inst.r3.op17 == op_sub_w;
    assign is_and   = id_inst.r3.op17 == op_and;
    assign is_or    = id_inst.r3.op17 == op_or;
    assign is_addi  = op10 == op_addi_w;
    assign is_ld    = op10 == op_ld_w;
    assign is_st    = op10 == op_st_w;
    assign is_lu12i = op7 == op_lu12i_w;
    assign is_beq   = id_inst.ri.op6 == op_beq;
    assign is_bne   = id_inst.ri.op6 == op_bne;

    assign is_3r  = is_add || is_sub || is_and || is_or;
    assign use_r1 = is_3r || is_addi || is_ld || is_st || is_beq || is_bne;
    // second port reads rk for 3R, rd for store and branch
    assign use_r2 = is_3r || is_st || is_beq || is_bne;

    assign raddr1 = id_inst.r3.rj;
    assign raddr2 = is_3r ? id_inst.r3.rk : id_inst.ri.rd;

    // r0 never matches a producer
    assign ex_hit1  = ex_fwd.valid && ex_fwd.dest != 5'd0 && ex_fwd.dest == raddr1;
    assign ex_hit2  = ex_fwd.valid && ex_fwd.dest != 5'd0 && ex_fwd.dest == raddr2;
    assign mem_hit1 = mem_fwd.valid && mem_fwd.dest != 5'd0 && mem_fwd.dest == raddr1;
    assign mem_hit2 = mem_fwd.valid && mem_fwd.dest != 5'd0 && mem_fwd.dest == raddr2;

    assign val1 = ex_hit1 ? ex_fwd.data : mem_hit1 ? mem_fwd.data : rdata1;
    assign val2 = ex_hit2 ? ex_fwd.data : mem_hit2 ? mem_fwd.data : rdata2;

    // load data not there until MEM
    assign load_use = ex_fwd.is_load && ((use_r1 && ex_hit1) || (use_r2 && ex_hit2));
    assign ready_go = !load_use;

    assign from_if.allowin = !id_valid || (ready_go && to_ex.allowin);

    assign br_taken  = id_valid && ready_go && to_ex.allowin &&
                       ((is_beq && val1 == val2) || (is_bne && val1 != val2));
    assign br_target = id_pc + {{14{offs16[15]}}, offs16, 2'b00};

    assign to_ex.valid  = id_valid && ready_go;
    assign to_ex.pc     = id_pc;
    assign to_ex.alu_op = is_sub   ? alu_sub :
                          is_and   ? alu_and :
                          is_or    ? alu_or  :
                          is_lu12i ? alu_lui : alu_add;
    assign to_ex.src1   = val1;
    assign to_ex.src2   = is_3r    ? val2 :
                          is_lu12i ? {si20, 12'b0} : imm_se12;
    assign to_ex.dest   = id_inst.ri.rd;
    // unknown encodings write nothing and touch no memory
    assign to_ex.rf_we  = is_3r || is_addi || is_lu12i || is_ld;
    assign to_ex.mem_re = is_ld;
    assign to_ex.mem_we = is_st;
    assign to_ex.store_data = val2;

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    id_ex_if.slave                  from_id,
    ex_mem_if.master                to_mem,
    fwd_if.producer                 fwd,
    output logic                    data_en,
    output logic [3:0]              data_we,
    output logic [la_pkg::xlen-1:0] data_addr,
    output logic [la_pkg::xlen-1:0] data_wdata
);
    import la_pkg::*;

    logic                    ex_valid;
    logic [xlen-1:0]         ex_pc;
    logic [alu_op_width-1:0] ex_alu_op;
    logic [xlen-1:0]         ex_src1, ex_src2, ex_store_data;
    logic [4:0]              ex_dest;
    logic                    ex_rf_we, ex_mem_re, ex_mem_we;
    logic [xlen-1:0]         result;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (from_id.allowin) begin
            ex_valid <= from_id.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_id.valid && from_id.allowin) begin
            ex_pc         <= from_id.pc;
            ex_alu_op     <= from_id.alu_op;
            ex_src1       <= from_id.src1;
            ex_src2       <= from_id.src2;
            ex_dest       <= from_id.dest;
            ex_rf_we      <= from_id.rf_we;
            ex_mem_re     <= from_id.mem_re;
            ex_mem_we     <= from_id.mem_we;
            ex_store_data <= from_id.store_data;
        end
    end

    always_comb begin
        case (ex_alu_op)
            alu_sub: result = ex_src1 - ex_src2;
            alu_and: result = ex_src1 & ex_src2;
            alu_or:  result = ex_src1 | ex_src2;
            alu_lui: result = ex_src2;
            default: result = ex_src1 + ex_src2;
        endcase
    end

    // single-cycle stage
    assign from_id.allowin = !ex_valid || to_mem.allowin;

    // ld/st address comes out of the adder
    assign data_en    = ex_valid && (ex_mem_re || ex_mem_we);
    assign data_we    = {4{ex_valid && ex_mem_we}};
    assign data_addr  = result;
    assign data_wdata = ex_store_data;

    assign to_mem.valid  = ex_valid;
    assign to_mem.pc     = ex_pc;
    assign to_mem.result = result;
    assign to_mem.dest   = ex_dest;
    assign to_mem.rf_we  = ex_rf_we;
    assign to_mem.mem_re = ex_mem_re;

    assign fwd.valid   = ex_valid && ex_rf_we;
    assign fwd.dest    = ex_dest;
    assign fwd.data    = result;
    assign fwd.is_load = ex_mem_re;

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
    input  logic                    clk,
    input  logic                    reset,
    ex_mem_if.slave                 from_ex,
    mem_wb_if.master                to_wb,
    fwd_if.producer                 fwd,
    input  logic [la_pkg::xlen-1:0] data_rdata
);
    import la_pkg::*;

    logic            mem_valid;
    logic [xlen-1:0] mem_pc;
    logic [xlen-1:0] mem_result;
    logic [4:0]      mem_dest;
    logic            mem_rf_we;
    logic            mem_re;
    logic [xlen-1:0] final_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (from_ex.allowin) begin
            mem_valid <= from_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_ex.valid && from_ex.allowin) begin
            mem_pc     <= from_ex.pc;
            mem_result <= from_ex.result;
            mem_dest   <= from_ex.dest;
            mem_rf_we  <= from_ex.rf_we;
            mem_re     <= from_ex.mem_re;
        end
    end

    // sram word arrives one cycle after the EX address
    assign final_result = mem_re ? data_rdata : mem_result;

    assign from_ex.allowin = !mem_valid || to_wb.allowin;

    assign to_wb.valid  = mem_valid;
    assign to_wb.pc     = mem_pc;
    assign to_wb.result = final_result;
    assign to_wb.dest   = mem_dest;
    assign to_wb.rf_we  = mem_rf_we;

    // value is final here, loads included
    assign fwd.valid   = mem_valid && mem_rf_we;
    assign fwd.dest    = mem_dest;
    assign fwd.data    = final_result;
    assign fwd.is_load = 1'b0;

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_stage (
    input  logic                    clk,
    input  logic                    reset,
    mem_wb_if.slave                 from_mem,
    output logic                    rf_we,
    output logic [4:0]              rf_waddr,
    output logic [la_pkg::xlen-1:0] rf_wdata,
    output logic [la_pkg::xlen-1:0] debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output logic [4:0]              debug_wb_rf_wnum,
    output logic [la_pkg::xlen-1:0] debug_wb_rf_wdata
);
    import la_pkg::*;

    logic            wb_valid;
    logic [xlen-1:0] wb_pc;
    logic [xlen-1:0] wb_result;
    logic [4:0]      wb_dest;
    logic            wb_rf_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= from_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_mem.valid) begin
            wb_pc     <= from_mem.pc;
            wb_result <= from_mem.result;
            wb_dest   <= from_mem.dest;
            wb_rf_we  <= from_mem.rf_we;
        end
    end

    // retire never blocks
    assign from_mem.allowin = 1'b1;

    // writes to r0 retire silently
    assign rf_we    = wb_valid && wb_rf_we && wb_dest != 5'd0;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_result;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

endmodule

`default_nettype wire

// ==== src/la_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module la_core_top (
    input  logic                    clk,
    input  logic                    reset,
    // instruction sram
    output logic                    inst_sram_en,
    output logic [3:0]              inst_sram_we,
    output logic [la_pkg::xlen-1:0] inst_sram_addr,
    output logic [la_pkg::xlen-1:0] inst_sram_wdata,
    input  logic [la_pkg::xlen-1:0] inst_sram_rdata,
    // data sram
    output logic                    data_sram_en,
    output logic [3:0]              data_sram_we,
    output logic [la_pkg::xlen-1:0] data_sram_addr,
    output logic [la_pkg::xlen-1:0] data_sram_wdata,
    input  logic [la_pkg::xlen-1:0] data_sram_rdata,
    // retire trace
    output logic [la_pkg::xlen-1:0] debug_wb_pc,
    output logic [3:0]              debug_wb_rf_we,
    output logic [4:0]              debug_wb_rf_wnum,
    output logic [la_pkg::xlen-1:0] debug_wb_rf_wdata
);
    import la_pkg::*;

    if_id_if  if_id ();
    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();
    fwd_if    ex_fwd ();
    fwd_if    mem_fwd ();

    logic            br_taken;
    logic [xlen-1:0] br_target;
    logic [4:0]      rf_raddr1, rf_raddr2;
    logic [xlen-1:0] rf_rdata1, rf_rdata2;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;

    fetch_stage u_fetch_stage (
        .clk        (clk),
        .reset      (reset),
        .inst_rdata (inst_sram_rdata),
        .inst_en    (inst_sram_en),
        .inst_addr  (inst_sram_addr),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .to_id      (if_id.master)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset     (reset),
        .from_if   (if_id.slave),
        .to_ex     (id_ex.master),
        .ex_fwd    (ex_fwd.consumer),
        .mem_fwd   (mem_fwd.consumer),
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .reset      (reset),
        .from_id    (id_ex.slave),
        .to_mem     (ex_mem.master),
        .fwd        (ex_fwd.producer),
        .data_en    (data_sram_en),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata)
    );

    memory_stage u_memory_stage (
        .clk        (clk),
        .reset      (reset),
        .from_ex    (ex_mem.slave),
        .to_wb      (mem_wb.master),
        .fwd        (mem_fwd.producer),
        .data_rdata (data_sram_rdata)
    );

    writeback_stage u_writeback_stage (
        .clk               (clk),
        .reset             (reset),
        .from_mem          (mem_wb.slave),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // instruction side is read only
    assign inst_sram_we    = 4'b0;
    assign inst_sram_wdata = '0;

endmodule

`default_nettype wire

// ==== tests/tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core;
    import la_pkg::*;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] byte_mask;

    // expected retire trace, program order
    logic [31:0] exp_pc [16];
    logic [4:0]  exp_wnum [16];
    logic [31:0] exp_wdata [16];

    int row;
    int cycles;

    la_core_top u_la_core_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // encoders, opcode bases taken from the ISA manual
    function automatic logic [31:0] asm_3r(input logic [31:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return op | {17'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] asm_ri12(input logic [31:0] op, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [11:0] si12);
        return op | {10'b0, si12, rj, rd};
    endfunction

    function automatic logic [31:0] asm_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return 32'h1400_0000 | {7'b0, si20, rd};
    endfunction

    function automatic logic [31:0] asm_br(input logic [31:0] op, input logic [4:0] rj,
                                           input logic [4:0] rd, input logic [15:0] offs16);
        return op | {6'b0, offs16, rj, rd};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - reset_pc;
        if (offs < 32'd256) begin
            return rom[offs[7:2]];
        end
        return 32'h0;
    endfunction

    // instruction rom, one cycle read latency
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= fetch_word(inst_sram_addr);
        end
    end

    assign byte_mask = {{8{data_sram_we[3]}}, {8{data_sram_we[2]}},
                        {8{data_sram_we[1]}}, {8{data_sram_we[0]}}};

    // data ram, 64 words
    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_we != 4'b0) begin
                ram[data_sram_addr[7:2]] <= (ram[data_sram_addr[7:2]] & ~byte_mask) |
                                            (data_sram_wdata & byte_mask);
            end else begin
                data_sram_rdata <= ram[data_sram_addr[7:2]];
            end
        end
    end

    task automatic load_program();
        int i;
        for (i = 0; i < 64; i++) begin
            rom[i] = 32'h0;
            ram[i] = 32'h0;
        end
        // opcode bases: add.w 00100000, sub.w 00110000, and 00148000, or 00150000
        // addi.w 02800000, ld.w 28800000, st.w 29800000, beq 58000000, bne 5c000000
        rom[0]  = asm_lu12i(5'd1, 20'h12345);
        rom[1]  = asm_ri12(32'h0280_0000, 5'd2, 5'd1, 12'h678);
        rom[2]  = asm_ri12(32'h0280_0000, 5'd3, 5'd0, 12'hfff);
        rom[3]  = asm_3r(32'h0010_0000, 5'd4, 5'd2, 5'd3);
        rom[4]  = asm_3r(32'h0011_0000, 5'd5, 5'd4, 5'd1);
        rom[5]  = asm_3r(32'h0014_8000, 5'd6, 5'd4, 5'd2);
        rom[6]  = asm_3r(32'h0015_0000, 5'd7, 5'd5, 5'd1);
        rom[7]  = asm_ri12(32'h2980_0000, 5'd2, 5'd0, 12'h010);
        rom[8]  = asm_ri12(32'h2980_0000, 5'd6, 5'd0, 12'h014);
        rom[9]  = asm_ri12(32'h2880_0000, 5'd8, 5'd0, 12'h010);
        // load-use on r8, then on r10
        rom[10] = asm_ri12(32'h0280_0000, 5'd9, 5'd8, 12'h001);
        rom[11] = asm_ri12(32'h2880_0000, 5'd10, 5'd0, 12'h014);
        rom[12] = asm_3r(32'h0010_0000, 5'd11, 5'd10, 5'd9);
        // write to r0, then read r0
        rom[13] = asm_ri12(32'h0280_0000, 5'd0, 5'd1, 12'h005);
        rom[14] = asm_3r(32'h0010_0000, 5'd12, 5'd0, 5'd1);
        // taken beq skips rom[16]
        rom[15] = asm_br(32'h5800_0000, 5'd2, 5'd8, 16'd2);
        rom[16] = asm_ri12(32'h0280_0000, 5'd13, 5'd0, 12'h111);
        // bne not taken
        rom[17] = asm_br(32'h5c00_0000, 5'd2, 5'd2, 16'd2);
        rom[18] = asm_ri12(32'h0280_0000, 5'd14, 5'd0, 12'h222);
        // taken bne on a forwarded r14 skips rom[20]
        rom[19] = asm_br(32'h5c00_0000, 5'd14, 5'd0, 16'd2);
        rom[20] = asm_ri12(32'h0280_0000, 5'd15, 5'd0, 12'h333);
        rom[21] = asm_ri12(32'h0280_0000, 5'd16, 5'd0, 12'h444);
        rom[22] = asm_ri12(32'h2980_0000, 5'd16, 5'd0, 12'h020);
        rom[23] = asm_ri12(32'h2880_0000, 5'd17, 5'd0, 12'h020);
        rom[24] = asm_3r(32'h0015_0000, 5'd18, 5'd17, 5'd0);
    endtask

    task automatic load_expected();
        exp_pc    = '{32'h1c00_0000, 32'h1c00_0004, 32'h1c00_0008, 32'h1c00_000c,
                      32'h1c00_0010, 32'h1c00_0014, 32'h1c00_0018, 32'h1c00_0024,
                      32'h1c00_0028, 32'h1c00_002c, 32'h1c00_0030, 32'h1c00_0038,
                      32'h1c00_0048, 32'h1c00_0054, 32'h1c00_005c, 32'h1c00_0060};
        exp_wnum  = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8,
                      5'd9, 5'd10, 5'd11, 5'd12, 5'd14, 5'd16, 5'd17, 5'd18};
        exp_wdata = '{32'h1234_5000, 32'h1234_5678, 32'hffff_ffff, 32'h1234_5677,
                      32'h0000_0677, 32'h1234_5670, 32'h1234_5677, 32'h1234_5678,
                      32'h1234_5679, 32'h1234_5670, 32'h2468_ace9, 32'h1234_5000,
                      32'h0000_0222, 32'h0000_0444, 32'h0000_0444, 32'h0000_0444};
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %08h, actual %08h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        load_program();
        load_expected();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        row    = 0;
        cycles = 0;
        // outputs settle after the rising edge, so sample on the falling one
        while (row < 16 && cycles < 500) begin
            @(negedge clk);
            cycles++;
            // instruction port is read only and always enabled
            compare_value("inst_sram_en", 32'h1, 32'(inst_sram_en));
            compare_value("inst_sram_we", 32'h0, 32'(inst_sram_we));
            compare_value("inst_sram_wdata", 32'h0, inst_sram_wdata);
            if (cycles == 1) begin
                // first cycle out of reset
                compare_value("first fetch address", reset_pc, inst_sram_addr);
                compare_value("data_sram_we after reset", 32'h0, 32'(data_sram_we));
                compare_value("debug_wb_rf_we after reset", 32'h0, 32'(debug_wb_rf_we));
            end
            if (debug_wb_rf_we != 4'b0) begin
                compare_value($sformatf("retire %0d we", row), 32'hf, 32'(debug_wb_rf_we));
                compare_value($sformatf("retire %0d pc", row), exp_pc[row], debug_wb_pc);
                compare_value($sformatf("retire %0d wnum", row), 32'(exp_wnum[row]),
                              32'(debug_wb_rf_wnum));
                compare_value($sformatf("retire %0d wdata", row), exp_wdata[row],
                              debug_wb_rf_wdata);
                row++;
            end
        end

        if (row < 16) begin
            $display("program never finished: %0d of 16 retires seen in 500 cycles", row);
            $display("Test failures found");
            $fatal(1, "timeout waiting for the final retire");
        end else begin
            compare_value("ram word 0x10", 32'h1234_5678, ram[4]);
            compare_value("ram word 0x14", 32'h1234_5670, ram[5]);
            compare_value("ram word 0x20", 32'h0000_0444, ram[8]);
            compare_value("ram word 0x18", 32'h0000_0000, ram[6]);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/la_pkg.sv
src/pipe_ifs.sv
src/regfile.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/writeback_stage.sv
src/la_core_top.sv
tests/tb_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -sv --top-module tb_core -f flist.f -o sim_tb_core

# the log decides pass or fail
./obj_dir/sim_tb_core | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
